// ==== verilog.f ====
common/knn_vote_pkg.sv
rtl/vote_step_counter.sv
rtl/vote_tally.sv
rtl/vote_argmax.sv
rtl/vote_ctrl_fsm.sv
rtl/knn_wb_regs.sv
rtl/knn_vote_top.sv
tb/knn_vote_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing
TOP        := knn_vote_tb
RTL_TOP    := knn_vote_top
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
PASS_MSG   := No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/knn_vote_tb.sv ====
`timescale 1ns/1ps

module knn_vote_tb
    import knn_vote_pkg::*;
();

    localparam int NUM_RUNS       = 200;
    localparam int WB_CYCLES      = 3;  // Worst case for one bus access.
    localparam int WRITE_CYCLES   = (NUM_NEIGHBORS + 1) * WB_CYCLES;
    localparam int POLL_CYCLES    = (NUM_NEIGHBORS + CLASS_NUM + 3) * WB_CYCLES;
    localparam int RUN_CYCLES     = NUM_NEIGHBORS + WRITE_CYCLES + CLASS_NUM + POLL_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * NUM_RUNS * RUN_CYCLES;
    localparam int DONE_LATENCY   = NUM_NEIGHBORS + CLASS_NUM + 1;

    logic    clk;
    logic    rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    done;
    int      cycle_count = 0;

    knn_vote_top dut_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run hung and did not finish within %0d cycles", cycle_count);
            $display("Errors found");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    task automatic fail_check(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "Stopping at the first mismatch");
    endtask

    task automatic check_result(input result_t got, input result_t exp, input string what);
        if (got !== exp) begin
            fail_check($sformatf("%s: label %0d votes %0d, expected label %0d votes %0d",
                                 what, got.label, got.votes, exp.label, exp.votes));
        end
    endtask

    task automatic check_label(input label_t got, input label_t exp, input string what);
        if (got !== exp) begin
            fail_check($sformatf("%s: label %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_status(input logic got_busy, input logic got_done,
                                input logic exp_busy, input logic exp_done, input string what);
        if (got_busy !== exp_busy || got_done !== exp_done) begin
            fail_check($sformatf("%s: busy %b done %b, expected busy %b done %b",
                                 what, got_busy, got_done, exp_busy, exp_done));
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string what);
        if (got != exp) begin
            fail_check($sformatf("%s: %0d cycles, expected %0d", what, got, exp));
        end
    endtask

    // Every access starts 1 ns after a rising edge and ends 1 ns after the ack edge.
    task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [DATA_W-1:0] dat);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.adr = adr;
        wb_req.dat = dat;
        do begin
            @(posedge clk);
            #1;
        end while (!wb_rsp.ack);
        wb_req = '0;
    endtask

    task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [DATA_W-1:0] dat);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.adr = adr;
        wb_req.dat = '0;
        do begin
            @(posedge clk);
            #1;
        end while (!wb_rsp.ack);
        dat    = wb_rsp.dat;
        wb_req = '0;
    endtask

    task automatic read_status(output logic busy, output logic st_done);
        logic [DATA_W-1:0] rdata;
        wb_read(ADR_W'(REG_CTRL_STATUS), rdata);
        busy    = rdata[0];
        st_done = rdata[1];
    endtask

    task automatic read_result(output result_t res);
        logic [DATA_W-1:0] rdata;
        wb_read(ADR_W'(REG_RESULT), rdata);
        res.label = rdata[LABEL_W-1:0];
        res.votes = rdata[RESULT_VOTES_LSB +: VOTE_W];
    endtask

    task automatic load_labels(input label_vec_t lbls);
        for (int n = 0; n < NUM_NEIGHBORS; n++) begin
            wb_write(ADR_W'(REG_LABEL_BASE) + ADR_W'(n), DATA_W'(lbls[n]));
        end
    endtask

    task automatic readback_labels(input label_vec_t exp, input string what);
        logic [DATA_W-1:0] rdata;
        for (int n = 0; n < NUM_NEIGHBORS; n++) begin
            wb_read(ADR_W'(REG_LABEL_BASE) + ADR_W'(n), rdata);
            check_label(label_t'(rdata[LABEL_W-1:0]), exp[n], $sformatf("%s, label %0d", what, n));
        end
    endtask

    task automatic start_run();
        wb_write(ADR_W'(REG_CTRL_STATUS), DATA_W'(1));
    endtask

    task automatic wait_done(input string what);
        logic busy;
        logic st_done;
        do begin
            read_status(busy, st_done);
        end while (!st_done);
        check_status(busy, st_done, 1'b0, 1'b1, what);
    endtask

    // Counts clock edges from start_cycle until the done output is seen high.
    task automatic wait_done_output(input int start_cycle, output int latency);
        do begin
            @(posedge clk);
            #1;
        end while (!done);
        latency = cycle_count - start_cycle;
    endtask

    task automatic random_labels(output label_vec_t lbls);
        for (int n = 0; n < NUM_NEIGHBORS; n++) begin
            lbls[n] = label_t'($urandom_range(7, 0));
        end
    endtask

    // Majority vote over labels 1 to CLASS_NUM, the lowest label winning a tie.
    task automatic compute_expected(input label_vec_t lbls, output result_t exp);
        int votes [CLASS_NUM+1];
        int best;
        int lbl;
        votes = '{default: 0};
        for (int n = 0; n < NUM_NEIGHBORS; n++) begin
            lbl = int'(lbls[n]);
            if (lbl >= 1 && lbl <= CLASS_NUM) begin
                votes[lbl]++;
            end
        end
        best = 1;
        for (int c = 2; c <= CLASS_NUM; c++) begin
            if (votes[c] > votes[best]) begin
                best = c;
            end
        end
        exp.label = label_t'(best);
        exp.votes = vote_t'(votes[best]);
    endtask

    task automatic classify_and_check(input label_vec_t lbls, input string what,
                                      output result_t got);
        result_t exp;
        load_labels(lbls);
        start_run();
        wait_done(what);
        read_result(got);
        compute_expected(lbls, exp);
        check_result(got, exp, what);
    endtask

    initial begin : stimulus
        label_vec_t  lbls;
        result_t     exp;
        result_t     got;
        logic        st_busy;
        logic        st_done;
        int          start_cycle;
        int          latency;

        wb_req = '0;
        rst_n  = 1'b0;
        void'($urandom(32'h24a0_8e65));
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        read_status(st_busy, st_done);
        check_status(st_busy, st_done, 1'b0, 1'b0, "status after reset");
        read_result(got);
        check_result(got, '0, "result after reset");
        check_status(1'b0, done, 1'b0, 1'b0, "done output after reset");

        for (int r = 0; r < 4; r++) begin
            random_labels(lbls);
            load_labels(lbls);
            readback_labels(lbls, $sformatf("readback set %0d", r));
        end

        lbls = {label_t'(3), label_t'(7), label_t'(0), label_t'(5),
                label_t'(5), label_t'(2), label_t'(2)};
        classify_and_check(lbls, "tie between labels 2 and 5", got);

        for (int r = 0; r < NUM_RUNS; r++) begin
            random_labels(lbls);
            classify_and_check(lbls, $sformatf("random run %0d", r), got);
        end

        lbls = '0;
        classify_and_check(lbls, "all labels 0", got);
        exp.label = label_t'(1);
        exp.votes = vote_t'(0);
        check_result(got, exp, "all labels 0, fixed value");

        // Label writes and a second start land while the engine is running.
        random_labels(lbls);
        load_labels(lbls);
        start_run();
        start_cycle = cycle_count;
        for (int k = 0; k < 3; k++) begin
            wb_write(ADR_W'(REG_LABEL_BASE) + ADR_W'(k), DATA_W'(label_t'(~lbls[k])));
        end
        start_run();
        read_status(st_busy, st_done);
        check_status(st_busy, st_done, 1'b1, 1'b0, "status during ignored writes");
        // A restarted run would push done past the latency of the first start.
        wait_done_output(start_cycle, latency);
        check_cycles(latency, DONE_LATENCY, "done latency with ignored start");
        wait_done("run with ignored writes");
        read_result(got);
        compute_expected(lbls, exp);
        check_result(got, exp, "result with ignored writes");
        readback_labels(lbls, "readback after ignored writes");

        random_labels(lbls);
        load_labels(lbls);
        start_run();
        start_cycle = cycle_count;
        wait_done_output(start_cycle, latency);
        check_cycles(latency, DONE_LATENCY, "done latency after start ack");
        read_result(got);
        compute_expected(lbls, exp);
        check_result(got, exp, "result of latency run");

        start_run();
        read_status(st_busy, st_done);
        check_status(st_busy, st_done, 1'b1, 1'b0, "status right after start");
        wait_done("busy then done run");

        $display("No errors");
        $finish;
    end

endmodule

// ==== rtl/knn_vote_top.sv ====
`timescale 1ns/1ps

module knn_vote_top
    import knn_vote_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp,
    output logic    done
);

    label_vec_t labels;
    result_t    result;
    tally_t     tally;
    step_t      index;
    logic       start;
    logic       start_accept;
    logic       busy;
    logic       last;
    logic       step_clear;
    logic       count_en;
    logic       scan;

    // A start that arrives mid-run must not wipe the tally or the result.
    assign start_accept = start && !busy;

    knn_wb_regs regs_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .busy   (busy),
        .done   (done),
        .result (result),
        .labels (labels),
        .start  (start)
    );

    vote_ctrl_fsm fsm_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .last       (last),
        .step_clear (step_clear),
        .count_en   (count_en),
        .scan       (scan),
        .busy       (busy),
        .done       (done)
    );

    vote_step_counter step_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .step_clear (step_clear),
        .scan       (scan),
        .index      (index),
        .last       (last)
    );

    vote_tally tally_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (start_accept),
        .count_en (count_en),
        .labels   (labels),
        .index    (index),
        .tally    (tally)
    );

    vote_argmax argmax_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (start_accept),
        .scan   (scan),
        .index  (index),
        .tally  (tally),
        .result (result)
    );

endmodule

// ==== rtl/knn_wb_regs.sv ====
`timescale 1ns/1ps

module knn_wb_regs
    import knn_vote_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  wb_req_t    wb_req,
    output wb_rsp_t    wb_rsp,
    input  logic       busy,
    input  logic       done,
    input  result_t    result,
    output label_vec_t labels,
    output logic       start
);

    logic              req;
    logic              wr;
    logic              ack_q;
    logic              start_q;
    logic              lbl_hit;
    logic [ADR_W-1:0]  lbl_idx;
    logic [DATA_W-1:0] rdata;
    logic [DATA_W-1:0] rdata_q;

    assign req = wb_req.cyc && wb_req.stb && !ack_q;  // A request not yet answered.
    assign wr  = req && wb_req.we;

    // Addresses below the label base wrap to large offsets and miss.
    assign lbl_idx = wb_req.adr - ADR_W'(REG_LABEL_BASE);
    assign lbl_hit = (lbl_idx < ADR_W'(NUM_NEIGHBORS));

    always_comb begin
        rdata = '0;
        case (reg_addr_e'(wb_req.adr))
            REG_CTRL_STATUS: begin
                rdata[0] = busy;
                rdata[1] = done;
            end
            REG_RESULT: begin
                rdata[LABEL_W-1:0]                 = result.label;
                rdata[RESULT_VOTES_LSB +: VOTE_W]  = result.votes;
            end
            default: begin
                for (int n = 0; n < NUM_NEIGHBORS; n++) begin
                    if (lbl_hit && lbl_idx == ADR_W'(n)) begin
                        rdata[LABEL_W-1:0] = labels[n];
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q   <= 1'b0;
            start_q <= 1'b0;
        end else begin
            ack_q   <= req;
            start_q <= wr && wb_req.adr == ADR_W'(REG_CTRL_STATUS) && wb_req.dat[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            labels <= '0;
        end else if (wr && lbl_hit && !busy) begin  // Labels are frozen during a run.
            for (int n = 0; n < NUM_NEIGHBORS; n++) begin
                if (lbl_idx == ADR_W'(n)) begin
                    labels[n] <= wb_req.dat[LABEL_W-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (req) begin
            rdata_q <= rdata;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rdata_q;
    assign start      = start_q;  // Lines up with ack.

endmodule

// ==== rtl/vote_ctrl_fsm.sv ====
`timescale 1ns/1ps

module vote_ctrl_fsm
    import knn_vote_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic last,
    output logic step_clear,
    output logic count_en,
    output logic scan,
    output logic busy,
    output logic done
);

    vote_state_e state;
    vote_state_e state_next;
    logic        start_ok;

    // Start is only honoured when no classification is running.
    assign start_ok = start && (state == ST_IDLE || state == ST_DONE);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start_ok) begin
                    state_next = ST_COUNT;
                end
            end
            ST_COUNT: begin
                if (last) begin
                    state_next = ST_SCAN;
                end
            end
            ST_SCAN: begin
                if (last) begin
                    state_next = ST_DONE;
                end
            end
            ST_DONE: begin
                if (start_ok) begin
                    state_next = ST_COUNT;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // The step counter restarts for the neighbour walk and again for the class scan.
    assign step_clear = start_ok || (state == ST_COUNT && last);
    assign count_en   = (state == ST_COUNT);
    assign scan       = (state == ST_SCAN);
    assign busy       = (state == ST_COUNT) || (state == ST_SCAN);
    assign done       = (state == ST_DONE);

endmodule

// ==== rtl/vote_argmax.sv ====
`timescale 1ns/1ps

module vote_argmax
    import knn_vote_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    clear,
    input  logic    scan,
    input  step_t   index,
    input  tally_t  tally,
    output result_t result
);

    vote_t cur_votes;

    always_comb begin
        cur_votes = '0;
        for (int c = 0; c < CLASS_NUM; c++) begin
            if (index == step_t'(c)) begin
                cur_votes = tally[c];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (clear) begin
            result <= '0;
        end else if (scan) begin
            if (index == '0) begin
                result.label <= label_t'(1);  // Class 1 seeds the search.
                result.votes <= cur_votes;
            end else if (cur_votes > result.votes) begin
                // Strictly greater, so ties stay with the lower label.
                result.label <= label_t'(index) + label_t'(1);
                result.votes <= cur_votes;
            end
        end
    end

endmodule

// ==== rtl/vote_tally.sv ====
`timescale 1ns/1ps

module vote_tally
    import knn_vote_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  logic       count_en,
    input  label_vec_t labels,
    input  step_t      index,
    output tally_t     tally
);

    label_t cur_label;

    always_comb begin
        cur_label = '0;
        for (int n = 0; n < NUM_NEIGHBORS; n++) begin
            if (index == step_t'(n)) begin
                cur_label = labels[n];
            end
        end
    end

    // Label 0 and labels above CLASS_NUM match no counter and cast no vote.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tally <= '0;
        end else if (clear) begin
            tally <= '0;
        end else if (count_en) begin
            for (int c = 0; c < CLASS_NUM; c++) begin
                if (cur_label == label_t'(c + 1)) begin
                    tally[c] <= tally[c] + vote_t'(1);
                end
            end
        end
    end

endmodule

// ==== rtl/vote_step_counter.sv ====
`timescale 1ns/1ps

module vote_step_counter
    import knn_vote_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  step_clear,
    input  logic  scan,
    output step_t index,
    output logic  last
);

    step_t final_idx;

    // Neighbour walk when scan is low, class scan when it is high.
    assign final_idx = scan ? step_t'(CLASS_NUM - 1) : step_t'(NUM_NEIGHBORS - 1);
    assign last      = (index == final_idx);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index <= '0;
        end else if (step_clear) begin
            index <= '0;
        end else if (index < final_idx) begin  // Holds once the final step is reached.
            index <= index + step_t'(1);
        end
    end

endmodule

// ==== common/knn_vote_pkg.sv ====
package knn_vote_pkg;

    localparam int NUM_NEIGHBORS    = 7;  // K of the vote.
    localparam int CLASS_NUM        = 6;
    localparam int LABEL_W          = 3;  // Label 0 plus labels 1 to 6.
    localparam int VOTE_W           = 3;  // Holds up to NUM_NEIGHBORS votes.
    localparam int STEP_W           = 3;
    localparam int ADR_W            = 4;  // Word address.
    localparam int DATA_W           = 16;
    localparam int RESULT_VOTES_LSB = 8;  // Votes field position in the result register.

    typedef logic [LABEL_W-1:0] label_t;
    typedef logic [VOTE_W-1:0]  vote_t;
    typedef logic [STEP_W-1:0]  step_t;

    typedef label_t [NUM_NEIGHBORS-1:0] label_vec_t;
    // Entry i counts the votes for label i+1.
    typedef vote_t [CLASS_NUM-1:0] tally_t;

    typedef struct packed {
        label_t label;
        vote_t  votes;
    } result_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADR_W-1:0]  adr;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COUNT,
        ST_SCAN,
        ST_DONE
    } vote_state_e;

    typedef enum logic [ADR_W-1:0] {
        REG_CTRL_STATUS = 4'd0,  // Write bit 0 starts, read bit 0 busy and bit 1 done.
        REG_RESULT      = 4'd1,
        REG_LABEL_BASE  = 4'd2   // Label n sits at REG_LABEL_BASE + n.
    } reg_addr_e;

endpackage
